//--- fb_pkg.sv
// Frontend memory shared types
`default_nettype none

package fb_pkg;

   // Byte address and data word widths
   localparam int ADDR_W = 16;
   localparam int DATA_W = 32;

   // Byte lanes in one data word
   localparam int LANES = DATA_W / 8;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;

   // Access size code, dbus only
   typedef logic [1:0] size_t;

   // One enable per byte lane
   typedef logic [LANES-1:0] be_t;

   // Size codes
   localparam size_t SIZE_BYTE = 2'd0;
   localparam size_t SIZE_HALF = 2'd1;
   localparam size_t SIZE_WORD = 2'd2;

endpackage

`default_nettype wire

//--- mbus_if.sv
// Memory bus interface
`timescale 1ns/1ps
`default_nettype none

interface mbus_if;

   // Command channel
   logic cmd_valid;
   logic cmd_ready;
   fb_pkg::addr_t cmd_addr;
   fb_pkg::size_t cmd_size;
   logic cmd_we;
   fb_pkg::be_t cmd_be;
   fb_pkg::data_t cmd_wdata;

   // Response channel
   logic rsp_valid;
   logic rsp_ready;
   fb_pkg::data_t rsp_data;

   // Bus master, both channels
   modport requester (
      output cmd_valid, cmd_addr, cmd_size, cmd_we, cmd_be, cmd_wdata, rsp_ready,
      input cmd_ready, rsp_valid, rsp_data
   );

   // Slave side, both channels
   modport responder (
      input cmd_valid, cmd_addr, cmd_size, cmd_we, cmd_be, cmd_wdata, rsp_ready,
      output cmd_ready, rsp_valid, rsp_data
   );

   // Router to bank, command only
   modport issuer (output cmd_valid, cmd_addr, cmd_size, cmd_we, cmd_be, cmd_wdata);

endinterface

`default_nettype wire

//--- fb_arbiter.sv
// Frontend bus arbiter
`timescale 1ns/1ps
`default_nettype none

module fb_arbiter (
   input logic clk,
   input logic reset,
   // Instruction bus
   input logic ibus_cmd_valid,
   output logic ibus_cmd_ready,
   input fb_pkg::addr_t ibus_cmd_addr,
   output logic ibus_rsp_valid,
   input logic ibus_rsp_ready,
   output fb_pkg::data_t ibus_rsp_data,
   // Data bus
   input logic dbus_cmd_valid,
   output logic dbus_cmd_ready,
   input fb_pkg::addr_t dbus_cmd_addr,
   input fb_pkg::size_t dbus_cmd_size,
   input logic dbus_cmd_we,
   input fb_pkg::data_t dbus_cmd_wdata,
   output logic dbus_rsp_valid,
   input logic dbus_rsp_ready,
   output fb_pkg::data_t dbus_rsp_data,
   // Shared memory bus
   mbus_if.requester mbus
);

   logic dbus_sel;
   logic owner_dbus_q;
   fb_pkg::addr_t addr;
   fb_pkg::size_t size;
   logic [1:0] lane;
   fb_pkg::be_t be;
   fb_pkg::data_t wdata;

   // Dbus wins whenever it asks
   assign dbus_sel = dbus_cmd_valid;

   // Dbus only waits for the router
   assign dbus_cmd_ready = mbus.cmd_ready;
   // Ibus loses to any dbus request
   assign ibus_cmd_ready = ~dbus_sel & mbus.cmd_ready;

   // Command mux
   assign addr = dbus_sel ? dbus_cmd_addr : ibus_cmd_addr;
   // Ibus is always a word read
   assign size = dbus_sel ? dbus_cmd_size : fb_pkg::SIZE_WORD;
   assign lane = addr[1:0];

   // Byte enables and lane placement of write data
   always_comb begin
      case (size)
         fb_pkg::SIZE_BYTE: begin
            be = fb_pkg::be_t'(1) << lane;
            wdata = fb_pkg::data_t'(dbus_cmd_wdata[7:0]) << {lane, 3'b000};
         end
         fb_pkg::SIZE_HALF: begin
            // Half-words sit on an even lane pair
            be = fb_pkg::be_t'(2'b11) << {lane[1], 1'b0};
            wdata = fb_pkg::data_t'(dbus_cmd_wdata[15:0]) << {lane[1], 4'b0000};
         end
         default: begin
            be = '1;
            wdata = dbus_cmd_wdata;
         end
      endcase
   end

   assign mbus.cmd_valid = dbus_sel ? dbus_cmd_valid : ibus_cmd_valid;
   assign mbus.cmd_addr = addr;
   assign mbus.cmd_size = size;
   assign mbus.cmd_we = dbus_sel & dbus_cmd_we;
   assign mbus.cmd_be = be;
   assign mbus.cmd_wdata = wdata;

   // Owner of the outstanding command
   always_ff @(posedge clk) begin
      if (reset) begin
         owner_dbus_q <= 1'b0;
      end else if (mbus.cmd_valid && mbus.cmd_ready) begin
         owner_dbus_q <= dbus_sel;
      end
   end

   // Response only to the owner
   assign dbus_rsp_valid = owner_dbus_q & mbus.rsp_valid;
   assign ibus_rsp_valid = ~owner_dbus_q & mbus.rsp_valid;
   assign mbus.rsp_ready = owner_dbus_q ? dbus_rsp_ready : ibus_rsp_ready;

   // Idle bus sees zero data
   assign dbus_rsp_data = {fb_pkg::DATA_W{owner_dbus_q}} & mbus.rsp_data;
   assign ibus_rsp_data = {fb_pkg::DATA_W{~owner_dbus_q}} & mbus.rsp_data;

endmodule

`default_nettype wire

//--- bank_router.sv
// Bank command router
`timescale 1ns/1ps
`default_nettype none

module bank_router #(
   parameter int NUM_BANKS = 4
) (
   input logic clk,
   input logic reset,
   // Upstream command side
   mbus_if.responder up,
   // One command port per bank
   mbus_if.issuer bank [NUM_BANKS],
   // Upstream response transfer done
   input logic rsp_done
);

   localparam int BANK_BITS = $clog2(NUM_BANKS);

   typedef logic [BANK_BITS-1:0] bank_idx_t;

   logic busy_q;
   logic cmd_xfer;
   bank_idx_t sel;
   logic [NUM_BANKS-1:0] valid_q;
   fb_pkg::addr_t word_q;
   logic we_q;
   fb_pkg::be_t be_q;
   fb_pkg::data_t wdata_q;

   // One transaction in flight at most
   assign up.cmd_ready = ~busy_q;
   assign cmd_xfer = up.cmd_valid & ~busy_q;

   // Bank bits sit above the byte lane
   assign sel = up.cmd_addr[2 +: BANK_BITS];

   always_ff @(posedge clk) begin
      if (reset) begin
         busy_q <= 1'b0;
         valid_q <= '0;
      end else begin
         // Single cycle strobe to the chosen bank
         valid_q <= '0;
         if (cmd_xfer) begin
            busy_q <= 1'b1;
            valid_q[sel] <= 1'b1;
         end else if (rsp_done) begin
            busy_q <= 1'b0;
         end
      end
   end

   // Payload shared by all banks
   always_ff @(posedge clk) begin
      if (cmd_xfer) begin
         // Word index within the bank
         word_q <= up.cmd_addr >> (2 + BANK_BITS);
         we_q <= up.cmd_we;
         be_q <= up.cmd_be;
         wdata_q <= up.cmd_wdata;
      end
   end

   for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
      assign bank[i].cmd_valid = valid_q[i];
      assign bank[i].cmd_addr = word_q;
      assign bank[i].cmd_we = we_q;
      assign bank[i].cmd_be = be_q;
      assign bank[i].cmd_wdata = wdata_q;
   end

endmodule

`default_nettype wire

//--- mem_bank.sv
// SRAM bank with byte lanes
`timescale 1ns/1ps
`default_nettype none

module mem_bank #(
   parameter int BANK_WORDS = 64
) (
   input logic clk,
   input logic reset,
   mbus_if.responder port
);

   localparam int IDX_W = $clog2(BANK_WORDS);

   typedef logic [IDX_W-1:0] idx_t;

   fb_pkg::data_t mem [BANK_WORDS];
   idx_t idx;
   fb_pkg::data_t merged;
   fb_pkg::data_t word_q;
   logic pend_q;
   logic rsp_valid_q;

   // Upper address bits are dropped
   assign idx = port.cmd_addr[IDX_W-1:0];

   // Stored word with enabled write lanes replaced
   always_comb begin
      merged = mem[idx];
      for (int i = 0; i < fb_pkg::LANES; i++) begin
         if (port.cmd_we && port.cmd_be[i]) begin
            merged[8*i +: 8] = port.cmd_wdata[8*i +: 8];
         end
      end
   end

   // Array access stage
   always_ff @(posedge clk) begin
      if (port.cmd_valid) begin
         if (port.cmd_we) begin
            mem[idx] <= merged;
         end
         // Read word or the newly written one
         word_q <= merged;
      end
   end

   // Response stage, held until taken
   always_ff @(posedge clk) begin
      if (reset) begin
         pend_q <= 1'b0;
         rsp_valid_q <= 1'b0;
      end else begin
         pend_q <= port.cmd_valid;
         if (pend_q) begin
            rsp_valid_q <= 1'b1;
         end else if (rsp_valid_q && port.rsp_ready) begin
            rsp_valid_q <= 1'b0;
         end
      end
   end

   assign port.rsp_valid = rsp_valid_q;
   // word_q stays put until the next command
   assign port.rsp_data = word_q;

endmodule

`default_nettype wire

//--- resp_merge.sv
// Bank response merger
`timescale 1ns/1ps
`default_nettype none

module resp_merge #(
   parameter int NUM_BANKS = 4
) (
   // Bank response side
   mbus_if.requester bank [NUM_BANKS],
   // Upstream response side
   mbus_if.responder up,
   // Upstream response transfer
   output logic rsp_done
);

   logic [NUM_BANKS-1:0] valid_vec;
   fb_pkg::data_t data_vec [NUM_BANKS];
   fb_pkg::data_t data_sel;

   for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
      assign valid_vec[i] = bank[i].rsp_valid;
      assign data_vec[i] = bank[i].rsp_data;
      // Ready goes back to the valid bank only
      assign bank[i].rsp_ready = valid_vec[i] & up.rsp_ready;
   end

   // AND-OR select, one bank valid at most
   always_comb begin
      data_sel = '0;
      for (int i = 0; i < NUM_BANKS; i++) begin
         if (valid_vec[i]) begin
            data_sel = data_sel | data_vec[i];
         end
      end
   end

   assign up.rsp_valid = |valid_vec;
   assign up.rsp_data = data_sel;

   // Frees the router
   assign rsp_done = up.rsp_valid & up.rsp_ready;

endmodule

`default_nettype wire

//--- fb_mem_top.sv
// Frontend memory subsystem
`timescale 1ns/1ps
`default_nettype none

module fb_mem_top #(
   parameter int NUM_BANKS = 4,
   parameter int BANK_WORDS = 64
) (
   input logic clk,
   input logic reset,
   // Instruction bus
   input logic ibus_cmd_valid,
   output logic ibus_cmd_ready,
   input fb_pkg::addr_t ibus_cmd_addr,
   output logic ibus_rsp_valid,
   input logic ibus_rsp_ready,
   output fb_pkg::data_t ibus_rsp_data,
   // Data bus
   input logic dbus_cmd_valid,
   output logic dbus_cmd_ready,
   input fb_pkg::addr_t dbus_cmd_addr,
   input fb_pkg::size_t dbus_cmd_size,
   input logic dbus_cmd_we,
   input fb_pkg::data_t dbus_cmd_wdata,
   output logic dbus_rsp_valid,
   input logic dbus_rsp_ready,
   output fb_pkg::data_t dbus_rsp_data
);

   logic rsp_done;

   // Arbiter to router and merger
   mbus_if mbus_up ();
   // Router and merger to each bank
   mbus_if mbus_bank [NUM_BANKS] ();

   fb_arbiter fb_arbiter_i (
      .clk(clk),
      .reset(reset),
      .ibus_cmd_valid(ibus_cmd_valid),
      .ibus_cmd_ready(ibus_cmd_ready),
      .ibus_cmd_addr(ibus_cmd_addr),
      .ibus_rsp_valid(ibus_rsp_valid),
      .ibus_rsp_ready(ibus_rsp_ready),
      .ibus_rsp_data(ibus_rsp_data),
      .dbus_cmd_valid(dbus_cmd_valid),
      .dbus_cmd_ready(dbus_cmd_ready),
      .dbus_cmd_addr(dbus_cmd_addr),
      .dbus_cmd_size(dbus_cmd_size),
      .dbus_cmd_we(dbus_cmd_we),
      .dbus_cmd_wdata(dbus_cmd_wdata),
      .dbus_rsp_valid(dbus_rsp_valid),
      .dbus_rsp_ready(dbus_rsp_ready),
      .dbus_rsp_data(dbus_rsp_data),
      .mbus(mbus_up)
   );

   bank_router #(.NUM_BANKS(NUM_BANKS)) bank_router_i (
      .clk(clk),
      .reset(reset),
      .up(mbus_up),
      .bank(mbus_bank),
      .rsp_done(rsp_done)
   );

   resp_merge #(.NUM_BANKS(NUM_BANKS)) resp_merge_i (
      .bank(mbus_bank),
      .up(mbus_up),
      .rsp_done(rsp_done)
   );

   // Word-interleaved banks
   for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
      mem_bank #(.BANK_WORDS(BANK_WORDS)) mem_bank_i (
         .clk(clk),
         .reset(reset),
         .port(mbus_bank[i])
      );
   end

endmodule

`default_nettype wire

//--- tb_fb_mem_top.sv
// Frontend memory testbench
`timescale 1ns/1ps
`default_nettype none

module tb_fb_mem_top;

   // Whole bank space, 4 banks of 64 words
   localparam int MEM_BYTES = 1024;
   localparam int TIMEOUT = 50;

   logic clk;
   logic reset;
   logic ibus_cmd_valid;
   logic ibus_cmd_ready;
   fb_pkg::addr_t ibus_cmd_addr;
   logic ibus_rsp_valid;
   logic ibus_rsp_ready;
   fb_pkg::data_t ibus_rsp_data;
   logic dbus_cmd_valid;
   logic dbus_cmd_ready;
   fb_pkg::addr_t dbus_cmd_addr;
   fb_pkg::size_t dbus_cmd_size;
   logic dbus_cmd_we;
   fb_pkg::data_t dbus_cmd_wdata;
   logic dbus_rsp_valid;
   logic dbus_rsp_ready;
   fb_pkg::data_t dbus_rsp_data;

   // Byte-wide reference memory
   logic [7:0] model [MEM_BYTES];
   fb_pkg::addr_t written [$];

   fb_mem_top fb_mem_top_i (
      .clk(clk),
      .reset(reset),
      .ibus_cmd_valid(ibus_cmd_valid),
      .ibus_cmd_ready(ibus_cmd_ready),
      .ibus_cmd_addr(ibus_cmd_addr),
      .ibus_rsp_valid(ibus_rsp_valid),
      .ibus_rsp_ready(ibus_rsp_ready),
      .ibus_rsp_data(ibus_rsp_data),
      .dbus_cmd_valid(dbus_cmd_valid),
      .dbus_cmd_ready(dbus_cmd_ready),
      .dbus_cmd_addr(dbus_cmd_addr),
      .dbus_cmd_size(dbus_cmd_size),
      .dbus_cmd_we(dbus_cmd_we),
      .dbus_cmd_wdata(dbus_cmd_wdata),
      .dbus_rsp_valid(dbus_rsp_valid),
      .dbus_rsp_ready(dbus_rsp_ready),
      .dbus_rsp_data(dbus_rsp_data)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #10 clk = ~clk;
      end
   end

   task automatic abort_run();
      $display("Verification failed");
      $fatal(1, "Simulation stopped at the first failure");
   endtask

   task automatic check_data(input string name, input fb_pkg::data_t expected,
                             input fb_pkg::data_t got);
      if (got !== expected) begin
         $display("Error: %s expected 0x%h got 0x%h", name, expected, got);
         abort_run();
      end
   endtask

   task automatic check_bit(input string name, input logic expected, input logic got);
      if (got !== expected) begin
         $display("Error: %s expected 0x%h got 0x%h", name, expected, got);
         abort_run();
      end
   endtask

   task automatic timeout_fail(input string what);
      $display("Timed out waiting for %s", what);
      abort_run();
   endtask

   // Upper address bits wrap onto the 1 KiB space
   function automatic int model_index(input fb_pkg::addr_t addr);
      return int'(addr) % MEM_BYTES;
   endfunction

   // Little-endian word at the aligned address
   function automatic fb_pkg::data_t model_word(input fb_pkg::addr_t addr);
      int base;
      base = model_index(addr) & ~3;
      return {model[base+3], model[base+2], model[base+1], model[base]};
   endfunction

   task automatic model_write(input fb_pkg::addr_t addr, input fb_pkg::size_t size,
                              input fb_pkg::data_t wdata);
      int base;
      base = model_index(addr);
      if (size == fb_pkg::SIZE_BYTE) begin
         model[base] = wdata[7:0];
      end else if (size == fb_pkg::SIZE_HALF) begin
         // Even lane pair
         base = base & ~1;
         model[base] = wdata[7:0];
         model[base+1] = wdata[15:8];
      end else begin
         base = base & ~3;
         for (int i = 0; i < 4; i++) begin
            model[base+i] = wdata[8*i +: 8];
         end
      end
   endtask

   task automatic start_dbus(input fb_pkg::addr_t addr, input fb_pkg::size_t size,
                             input logic we, input fb_pkg::data_t wdata);
      dbus_cmd_valid = 1'b1;
      dbus_cmd_addr = addr;
      dbus_cmd_size = size;
      dbus_cmd_we = we;
      dbus_cmd_wdata = wdata;
   endtask

   task automatic start_ibus(input fb_pkg::addr_t addr);
      ibus_cmd_valid = 1'b1;
      ibus_cmd_addr = addr;
   endtask

   task automatic set_rsp_ready(input logic is_dbus, input logic value);
      if (is_dbus) begin
         dbus_rsp_ready = value;
      end else begin
         ibus_rsp_ready = value;
      end
   endtask

   // The bus without the command sees no response and zero data
   task automatic check_other_idle(input logic is_dbus);
      if (is_dbus) begin
         check_bit("ibus_rsp_valid", 1'b0, ibus_rsp_valid);
         check_data("ibus_rsp_data", '0, ibus_rsp_data);
      end else begin
         check_bit("dbus_rsp_valid", 1'b0, dbus_rsp_valid);
         check_data("dbus_rsp_data", '0, dbus_rsp_data);
      end
   endtask

   // Sampled at falling edges, transfer on the next rising edge
   task automatic wait_cmd_ready(input logic is_dbus);
      int cycles;
      logic ready;
      cycles = 0;
      ready = 1'b0;
      while (!ready) begin
         @(negedge clk);
         // Dbus request blocks the ibus
         if (dbus_cmd_valid) begin
            check_bit("ibus_cmd_ready", 1'b0, ibus_cmd_ready);
         end
         ready = is_dbus ? dbus_cmd_ready : ibus_cmd_ready;
         cycles++;
         if (cycles > TIMEOUT) begin
            timeout_fail(is_dbus ? "dbus_cmd_ready" : "ibus_cmd_ready");
         end
      end
      @(posedge clk);
      #2;
      if (is_dbus) begin
         dbus_cmd_valid = 1'b0;
      end else begin
         ibus_cmd_valid = 1'b0;
      end
   endtask

   // Response with stall cycles of rsp_ready low
   task automatic collect_rsp(input logic is_dbus, input int stall,
                              input fb_pkg::data_t expected);
      int cycles;
      fb_pkg::data_t held;
      string vname;
      string dname;
      if (is_dbus) begin
         vname = "dbus_rsp_valid";
         dname = "dbus_rsp_data";
      end else begin
         vname = "ibus_rsp_valid";
         dname = "ibus_rsp_data";
      end
      cycles = 0;
      if (stall == 0) begin
         set_rsp_ready(is_dbus, 1'b1);
      end
      @(negedge clk);
      check_other_idle(is_dbus);
      while (!(is_dbus ? dbus_rsp_valid : ibus_rsp_valid)) begin
         cycles++;
         if (cycles > TIMEOUT) begin
            timeout_fail(vname);
         end
         @(negedge clk);
         check_other_idle(is_dbus);
      end
      held = is_dbus ? dbus_rsp_data : ibus_rsp_data;
      check_data(dname, expected, held);
      for (int k = 0; k < stall; k++) begin
         // Busy memory takes no new command
         check_bit("ibus_cmd_ready", 1'b0, ibus_cmd_ready);
         check_bit("dbus_cmd_ready", 1'b0, dbus_cmd_ready);
         @(posedge clk);
         #2;
         if (k == stall - 1) begin
            set_rsp_ready(is_dbus, 1'b1);
         end
         @(negedge clk);
         check_other_idle(is_dbus);
         check_bit(vname, 1'b1, is_dbus ? dbus_rsp_valid : ibus_rsp_valid);
         check_data(dname, held, is_dbus ? dbus_rsp_data : ibus_rsp_data);
      end
      @(posedge clk);
      #2;
      set_rsp_ready(is_dbus, 1'b0);
   endtask

   task automatic dbus_access(input fb_pkg::addr_t addr, input fb_pkg::size_t size,
                              input logic we, input fb_pkg::data_t wdata, input int stall);
      fb_pkg::data_t expected;
      start_dbus(addr, size, we, wdata);
      wait_cmd_ready(1'b1);
      if (we) begin
         model_write(addr, size, wdata);
      end
      // Writes answer with the merged word
      expected = model_word(addr);
      collect_rsp(1'b1, stall, expected);
   endtask

   task automatic ibus_read(input fb_pkg::addr_t addr, input int stall);
      start_ibus(addr);
      wait_cmd_ready(1'b0);
      collect_rsp(1'b0, stall, model_word(addr));
   endtask

   initial begin
      fb_pkg::addr_t addr;
      fb_pkg::addr_t iaddr;
      fb_pkg::size_t size;
      logic we;
      fb_pkg::data_t exp_d;
      void'($urandom(32'hbae7d725));
      reset = 1'b1;
      ibus_cmd_valid = 1'b0;
      ibus_cmd_addr = '0;
      ibus_rsp_ready = 1'b0;
      dbus_cmd_valid = 1'b0;
      dbus_cmd_addr = '0;
      dbus_cmd_size = fb_pkg::SIZE_WORD;
      dbus_cmd_we = 1'b0;
      dbus_cmd_wdata = '0;
      dbus_rsp_ready = 1'b0;

      // Reset, no response on either bus
      for (int i = 0; i < 3; i++) begin
         @(posedge clk);
         #1;
         check_bit("ibus_rsp_valid", 1'b0, ibus_rsp_valid);
         check_bit("dbus_rsp_valid", 1'b0, dbus_rsp_valid);
      end
      #1;
      reset = 1'b0;
      for (int i = 0; i < 2; i++) begin
         @(negedge clk);
         check_bit("ibus_rsp_valid", 1'b0, ibus_rsp_valid);
         check_bit("dbus_rsp_valid", 1'b0, dbus_rsp_valid);
         check_bit("ibus_cmd_ready", 1'b1, ibus_cmd_ready);
         check_bit("dbus_cmd_ready", 1'b1, dbus_cmd_ready);
      end
      @(posedge clk);
      #2;

      // Fill every word of every bank
      for (int a = 0; a < MEM_BYTES; a += 4) begin
         dbus_access(fb_pkg::addr_t'(a), fb_pkg::SIZE_WORD, 1'b1, $urandom, 0);
      end
      for (int n = 0; n < 60; n++) begin
         ibus_read(fb_pkg::addr_t'($urandom), $urandom_range(0, 1));
      end

      // Byte and half-word writes, read back later
      for (int n = 0; n < 40; n++) begin
         addr = fb_pkg::addr_t'($urandom);
         if ($urandom_range(0, 1) == 1) begin
            size = fb_pkg::SIZE_HALF;
            addr[0] = 1'b0;
         end else begin
            size = fb_pkg::SIZE_BYTE;
         end
         dbus_access(addr, size, 1'b1, $urandom, 0);
         written.push_back(addr);
      end
      foreach (written[i]) begin
         dbus_access(written[i], fb_pkg::SIZE_WORD, 1'b0, '0, 0);
      end

      // Both buses ask in the same cycle
      for (int n = 0; n < 20; n++) begin
         addr = fb_pkg::addr_t'($urandom);
         iaddr = fb_pkg::addr_t'($urandom);
         we = 1'(($urandom_range(0, 1)));
         start_ibus(iaddr);
         start_dbus(addr, fb_pkg::SIZE_WORD, we, $urandom);
         wait_cmd_ready(1'b1);
         if (we) begin
            model_write(addr, fb_pkg::SIZE_WORD, dbus_cmd_wdata);
         end
         exp_d = model_word(addr);
         collect_rsp(1'b1, $urandom_range(0, 3), exp_d);
         wait_cmd_ready(1'b0);
         collect_rsp(1'b0, $urandom_range(0, 3), model_word(iaddr));
      end

      // Mixed traffic with long response stalls
      for (int n = 0; n < 80; n++) begin
         addr = fb_pkg::addr_t'($urandom);
         if ($urandom_range(0, 1) == 1) begin
            ibus_read(addr, $urandom_range(0, 6));
         end else begin
            size = fb_pkg::size_t'($urandom_range(0, 2));
            if (size == fb_pkg::SIZE_HALF) begin
               addr[0] = 1'b0;
            end
            we = 1'(($urandom_range(0, 1)));
            dbus_access(addr, size, we, $urandom, $urandom_range(0, 6));
         end
      end

      $display("Verification passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog.f
fb_pkg.sv
mbus_if.sv
fb_arbiter.sv
bank_router.sv
mem_bank.sv
resp_merge.sv
fb_mem_top.sv
tb_fb_mem_top.sv

//--- Bender.yml
package:
  name: fb_mem

sources:
  - fb_pkg.sv
  - mbus_if.sv
  - fb_arbiter.sv
  - bank_router.sv
  - mem_bank.sv
  - resp_merge.sv
  - fb_mem_top.sv
  - target: test
    files:
      - tb_fb_mem_top.sv
